/* sources.f */
hdl/capture_pkg.sv
hdl/frame_sampler.sv
hdl/pixel_packer.sv
hdl/capture_ctrl.sv
hdl/dmem.sv
hdl/seg7_hex6.sv
hdl/capture_top.sv
bench/capture_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the capture testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=capture_sim
LOG=sim.log

verilator --binary --timing -f sources.f --top-module capture_tb \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# Verdict comes from the log
if grep -q "tests failed" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if ! grep -q "all tests passed" "$LOG"; then
	echo "Simulation ended without a pass report"
	exit 1
fi

echo "Simulation PASSED"
exit 0

/* bench/capture_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module capture_tb;

	// Clock and reset
	logic CLOCK_50;
	logic arst_n;

	// Host handshake and sensor stream
	logic                cap_req;
	logic                fval;
	logic                lval;
	capture_pkg::pixel_t pix_d;

	// Host memory port
	capture_pkg::haddr_t     host_addr;
	capture_pkg::host_word_t host_wdata;
	logic                    host_wr;
	logic                    host_rd;

	// DUT responses
	logic                    cap_ack;
	capture_pkg::host_word_t host_rdata;
	logic [6:0]              hex0;
	logic [6:0]              hex1;
	logic [6:0]              hex2;
	logic [6:0]              hex3;
	logic [6:0]              hex4;
	logic [6:0]              hex5;

	integer seed;

	// Kept pixels of the most recent frame, in capture order
	capture_pkg::pixel_t model_pix [$];

	capture_top UUT (
		.CLOCK_50   (CLOCK_50),
		.arst_n     (arst_n),
		.cap_req    (cap_req),
		.cap_ack    (cap_ack),
		.fval       (fval),
		.lval       (lval),
		.pix_d      (pix_d),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_wr    (host_wr),
		.host_rd    (host_rd),
		.host_rdata (host_rdata),
		.HEX0       (hex0),
		.HEX1       (hex1),
		.HEX2       (hex2),
		.HEX3       (hex3),
		.HEX4       (hex4),
		.HEX5       (hex5)
	);

	// 10 ns clock
	initial begin
		CLOCK_50 = 1'b0;
		forever #5 CLOCK_50 = ~CLOCK_50;
	end

	// Drive point, just after a rising edge
	task automatic next_cycle;
		@(posedge CLOCK_50);
		#1;
	endtask

	task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// Poll cap_ack until it reaches a level
	task automatic wait_ack(input logic level, input int limit);
		int cycles;
		cycles = 0;
		while (cap_ack !== level) begin
			if (cycles >= limit) begin
				$display("Timeout: cap_ack did not reach %0b within %0d cycles", level, limit);
				$display("tests failed");
				$fatal(1);
			end else begin
				next_cycle();
				cycles++;
			end
		end
	endtask

	// Lit segments in gfedcba order, inverted for the active-low display
	function automatic logic [6:0] expected_segments(input logic [3:0] digit);
		logic [6:0] lit;
		case (digit)
			4'h0: lit = 7'h3f;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5b;
			4'h3: lit = 7'h4f;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6d;
			4'h6: lit = 7'h7d;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7f;
			4'h9: lit = 7'h6f;
			4'ha: lit = 7'h77;
			4'hb: lit = 7'h7c;
			4'hc: lit = 7'h39;
			4'hd: lit = 7'h5e;
			4'he: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	// Pixels the memory can hold out of the last frame
	function automatic int expected_kept;
		int kept;
		if (model_pix.size() > capture_pkg::MAX_PIXELS)
			kept = capture_pkg::MAX_PIXELS;
		else
			kept = model_pix.size();
		return kept;
	endfunction

	// Sensor idle, frame flag held at a given level
	task automatic sensor_blank(input logic frame, input int cycles);
		for (int i = 0; i < cycles; i++) begin
			fval = frame;
			lval = 1'b0;
			next_cycle();
		end
	endtask

	// One frame with random pixels, model keeps every second pixel of every second line
	task automatic send_frame(input int lines, input int ppl);
		int rnd;
		model_pix.delete();
		sensor_blank(1'b0, 2);
		for (int row = 0; row < lines; row++) begin
			sensor_blank(1'b1, 2);
			for (int col = 0; col < ppl; col++) begin
				rnd = $random(seed);
				fval = 1'b1;
				lval = 1'b1;
				pix_d = rnd[11:0];
				if ((row % capture_pkg::DECIM == 0) && (col % capture_pkg::DECIM == 0))
					model_pix.push_back(rnd[11:0]);
				next_cycle();
			end
		end
		sensor_blank(1'b1, 2);
		sensor_blank(1'b0, 2);
	endtask

	task automatic host_write(input int addr, input logic [15:0] data);
		host_addr = 11'(addr);
		host_wdata = data;
		host_wr = 1'b1;
		next_cycle();
		host_wr = 1'b0;
	endtask

	// Data is registered on the edge after host_rd
	task automatic host_read(input int addr, output logic [15:0] data);
		host_addr = 11'(addr);
		host_rd = 1'b1;
		next_cycle();
		host_rd = 1'b0;
		data = host_rdata;
	endtask

	// Second half of the four-phase exchange
	task automatic finish_capture;
		wait_ack(1'b1, 100);
		cap_req = 1'b0;
		wait_ack(1'b0, 10);
	endtask

	task automatic run_capture(input int lines, input int ppl);
		cap_req = 1'b1;
		next_cycle();
		send_frame(lines, ppl);
		finish_capture();
	endtask

	task automatic check_display(input int count);
		logic [23:0] value;
		value = 24'(count);
		check_value(16'(hex0), 16'(expected_segments(value[3:0])), "HEX0 digit");
		check_value(16'(hex1), 16'(expected_segments(value[7:4])), "HEX1 digit");
		check_value(16'(hex2), 16'(expected_segments(value[11:8])), "HEX2 digit");
		check_value(16'(hex3), 16'(expected_segments(value[15:12])), "HEX3 digit");
		check_value(16'(hex4), 16'(expected_segments(value[19:16])), "HEX4 digit");
		check_value(16'(hex5), 16'(expected_segments(value[23:20])), "HEX5 digit");
	endtask

	// Stored pixels, then zero fill up to the end of the last word
	task automatic check_capture;
		int kept;
		int top;
		logic [15:0] data;
		kept = expected_kept();
		top = ((kept + capture_pkg::PIX_PER_WORD - 1) / capture_pkg::PIX_PER_WORD) *
			capture_pkg::PIX_PER_WORD;
		for (int a = 0; a < top; a++) begin
			host_read(a, data);
			if (a < kept)
				check_value(data, 16'(model_pix[a]), $sformatf("pixel at address %0d", a));
			else
				check_value(data, 16'h0000, $sformatf("zero fill at address %0d", a));
		end
		check_display(kept);
	endtask

	task automatic reset_and_host_test;
		int addrs [4] = '{0, 17, 1023, 2047};
		logic [15:0] data;
		check_value(16'(cap_ack), 16'h0, "cap_ack after reset");
		check_display(0);
		for (int i = 0; i < 4; i++)
			host_write(addrs[i], 16'(addrs[i] * 257 + 16'h1234));
		for (int i = 0; i < 4; i++) begin
			host_read(addrs[i], data);
			check_value(data, 16'(addrs[i] * 257 + 16'h1234), "host write and read back");
		end
	endtask

	task automatic partial_word_test;
		logic [15:0] data;
		// Markers inside and beyond the last written word
		host_write(90, 16'h0fff);
		host_write(200, 16'hbeef);
		run_capture(10, 34);
		// 17x5 kept pixels
		check_display(85);
		check_capture();
		host_read(200, data);
		check_value(data, 16'hbeef, "host value beyond the capture");
	endtask

	task automatic overflow_test;
		host_write(2047, 16'hcafe);
		run_capture(50, 200);
		// Memory full at 2048 pixels
		check_display(2048);
		check_capture();
	endtask

	// Request lands mid-frame, so only the following frame is stored
	task automatic mid_frame_request_test;
		fork
			send_frame(12, 20);
			begin
				repeat (60) next_cycle();
				cap_req = 1'b1;
			end
		join
		send_frame(12, 20);
		finish_capture();
		check_capture();
	endtask

	task automatic handshake_order_test;
		cap_req = 1'b1;
		next_cycle();
		send_frame(6, 16);
		wait_ack(1'b1, 100);
		// Ack must hold while the request stays up
		repeat (5) begin
			next_cycle();
			check_value(16'(cap_ack), 16'h1, "cap_ack held while cap_req high");
		end
		cap_req = 1'b0;
		next_cycle();
		check_value(16'(cap_ack), 16'h0, "cap_ack one cycle after cap_req low");
		check_capture();
		run_capture(8, 24);
		check_capture();
	endtask

	initial begin
		seed = 32'h3ffdc95f;
		arst_n = 1'b0;
		cap_req = 1'b0;
		fval = 1'b0;
		lval = 1'b0;
		pix_d = '0;
		host_addr = '0;
		host_wdata = '0;
		host_wr = 1'b0;
		host_rd = 1'b0;
		repeat (5) @(posedge CLOCK_50);
		#1;
		arst_n = 1'b1;
		next_cycle();

		reset_and_host_test();
		// 64x40 frame keeps 640 pixels
		run_capture(40, 64);
		check_display(640);
		check_capture();
		partial_word_test();
		overflow_test();
		mid_frame_request_test();
		handshake_order_test();

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/capture_top.sv */
`timescale 1ns/10ps
`default_nettype none

module capture_top (
	input  wire                        CLOCK_50,
	input  wire                        arst_n,
	input  wire                        cap_req,
	output logic                       cap_ack,
	input  wire                        fval,
	input  wire                        lval,
	input  wire capture_pkg::pixel_t     pix_d,
	input  wire capture_pkg::haddr_t     host_addr,
	input  wire capture_pkg::host_word_t host_wdata,
	input  wire                        host_wr,
	input  wire                        host_rd,
	output capture_pkg::host_word_t    host_rdata,
	output logic [6:0]                 HEX0,
	output logic [6:0]                 HEX1,
	output logic [6:0]                 HEX2,
	output logic [6:0]                 HEX3,
	output logic [6:0]                 HEX4,
	output logic [6:0]                 HEX5
);

	// Controller and sampler
	logic arm;
	logic cap_done;

	// Sampler to packer
	logic                    pix_valid;
	capture_pkg::pixel_t     pix_data;
	logic                    pix_last;
	capture_pkg::pix_count_t pix_count;

	// Packer to memory wide port
	logic                   wr_en;
	capture_pkg::waddr_t    wr_addr;
	capture_pkg::mem_word_t wr_data;

	capture_ctrl u_ctrl (
		.CLOCK_50 (CLOCK_50),
		.arst_n   (arst_n),
		.cap_req  (cap_req),
		.cap_done (cap_done),
		.arm      (arm),
		.cap_ack  (cap_ack)
	);

	frame_sampler u_sampler (
		.CLOCK_50  (CLOCK_50),
		.arst_n    (arst_n),
		.arm       (arm),
		.fval      (fval),
		.lval      (lval),
		.pix_d     (pix_d),
		.pix_valid (pix_valid),
		.pix_data  (pix_data),
		.pix_last  (pix_last),
		.pix_count (pix_count)
	);

	pixel_packer u_packer (
		.CLOCK_50  (CLOCK_50),
		.arst_n    (arst_n),
		.pix_valid (pix_valid),
		.pix_data  (pix_data),
		.pix_last  (pix_last),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.cap_done  (cap_done)
	);

	// Shared data memory, host on the narrow side
	dmem u_dmem (
		.CLOCK_50   (CLOCK_50),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_wr    (host_wr),
		.host_rd    (host_rd),
		.host_rdata (host_rdata),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	// Kept-pixel count shown in hex
	seg7_hex6 u_seg (
		.value ({{(24 - $bits(capture_pkg::pix_count_t)){1'b0}}, pix_count}),
		.hex0  (HEX0),
		.hex1  (HEX1),
		.hex2  (HEX2),
		.hex3  (HEX3),
		.hex4  (HEX4),
		.hex5  (HEX5)
	);

endmodule

`default_nettype wire

/* hdl/seg7_hex6.sv */
`timescale 1ns/10ps
`default_nettype none

module seg7_hex6 (
	input  wire  [23:0] value,
	output logic [6:0]  hex0,
	output logic [6:0]  hex1,
	output logic [6:0]  hex2,
	output logic [6:0]  hex3,
	output logic [6:0]  hex4,
	output logic [6:0]  hex5
);

	// Active low, bit order gfedcba
	function automatic logic [6:0] seg_decode(input logic [3:0] nib);
		case (nib)
			4'h0: seg_decode = 7'b1000000;
			4'h1: seg_decode = 7'b1111001;
			4'h2: seg_decode = 7'b0100100;
			4'h3: seg_decode = 7'b0110000;
			4'h4: seg_decode = 7'b0011001;
			4'h5: seg_decode = 7'b0010010;
			4'h6: seg_decode = 7'b0000010;
			4'h7: seg_decode = 7'b1111000;
			4'h8: seg_decode = 7'b0000000;
			4'h9: seg_decode = 7'b0010000;
			4'ha: seg_decode = 7'b0001000;
			4'hb: seg_decode = 7'b0000011;
			4'hc: seg_decode = 7'b1000110;
			4'hd: seg_decode = 7'b0100001;
			4'he: seg_decode = 7'b0000110;
			default: seg_decode = 7'b0001110;
		endcase
	endfunction

	// Digit 0 is the least significant nibble
	assign hex0 = seg_decode(value[3:0]);
	assign hex1 = seg_decode(value[7:4]);
	assign hex2 = seg_decode(value[11:8]);
	assign hex3 = seg_decode(value[15:12]);
	assign hex4 = seg_decode(value[19:16]);
	assign hex5 = seg_decode(value[23:20]);

endmodule

`default_nettype wire

/* hdl/dmem.sv */
`timescale 1ns/10ps
`default_nettype none

module dmem (
	input  wire                        CLOCK_50,
	input  wire capture_pkg::haddr_t     host_addr,
	input  wire capture_pkg::host_word_t host_wdata,
	input  wire                        host_wr,
	input  wire                        host_rd,
	output capture_pkg::host_word_t    host_rdata,
	input  wire                        wr_en,
	input  wire capture_pkg::waddr_t     wr_addr,
	input  wire capture_pkg::mem_word_t  wr_data
);

	// 128 packed words
	capture_pkg::mem_word_t mem [capture_pkg::MAX_PIXELS / capture_pkg::PIX_PER_WORD];

	// Host address split into word and lane
	capture_pkg::waddr_t                          host_word;
	logic [$clog2(capture_pkg::PIX_PER_WORD)-1:0] host_lane;

	assign host_word = host_addr[$bits(capture_pkg::haddr_t)-1 -: $bits(capture_pkg::waddr_t)];
	assign host_lane = host_addr[$clog2(capture_pkg::PIX_PER_WORD)-1:0];

	always_ff @(posedge CLOCK_50) begin
		// Capture side writes whole words
		if (wr_en)
			mem[wr_addr] <= wr_data;

		// Host side touches a single lane
		if (host_wr)
			mem[host_word][host_lane * $bits(capture_pkg::host_word_t) +:
				$bits(capture_pkg::host_word_t)] <= host_wdata;

		// Registered read, data one cycle after host_rd
		if (host_rd)
			host_rdata <= mem[host_word][host_lane * $bits(capture_pkg::host_word_t) +:
				$bits(capture_pkg::host_word_t)];
	end

endmodule

`default_nettype wire

/* hdl/capture_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module capture_ctrl (
	input  wire  CLOCK_50,
	input  wire  arst_n,
	input  wire  cap_req,
	input  wire  cap_done,
	output logic arm,
	output logic cap_ack
);

	typedef enum logic [1:0] {
		IDLE,
		ARMED,
		CAPTURE,
		DONE
	} capture_state_t;

	capture_state_t state;
	capture_state_t state_n;

	always_comb begin
		state_n = state;
		case (state)
			// Request only accepted with ack low
			IDLE: begin
				if (cap_req)
					state_n = ARMED;
			end
			// First cycle the sampler sees arm
			ARMED: begin
				if (cap_done)
					state_n = DONE;
				else
					state_n = CAPTURE;
			end
			// Wait for the packer to finish the frame
			CAPTURE: begin
				if (cap_done)
					state_n = DONE;
			end
			// Hold ack until the host drops its request
			DONE: begin
				if (!cap_req)
					state_n = IDLE;
			end
			default: begin
				state_n = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n)
			state <= IDLE;
		else
			state <= state_n;
	end

	// Outputs decoded from the state register
	assign arm     = (state == ARMED) || (state == CAPTURE);
	assign cap_ack = (state == DONE);

endmodule

`default_nettype wire

/* hdl/pixel_packer.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_packer (
	input  wire                      CLOCK_50,
	input  wire                      arst_n,
	input  wire                      pix_valid,
	input  wire capture_pkg::pixel_t pix_data,
	input  wire                      pix_last,
	output logic                     wr_en,
	output capture_pkg::waddr_t      wr_addr,
	output capture_pkg::mem_word_t   wr_data,
	output logic                     cap_done
);

	// Lane slot for the next pixel
	logic [$clog2(capture_pkg::PIX_PER_WORD)-1:0] lane_q;

	// Word under assembly
	capture_pkg::mem_word_t buf_q;
	capture_pkg::mem_word_t word_n;
	capture_pkg::waddr_t    addr_q;

	logic word_full;
	logic flush;

	// Fresh word starts all zero, so a partial word is zero-filled
	always_comb begin
		word_n = (lane_q == '0) ? '0 : buf_q;
		if (pix_valid)
			word_n[lane_q * $bits(capture_pkg::host_word_t) +: $bits(capture_pkg::host_word_t)]
				= capture_pkg::host_word_t'(pix_data);
	end

	assign word_full = pix_valid && (lane_q == capture_pkg::PIX_PER_WORD - 1);

	// Last with an empty buffer finishes without a write
	assign flush = word_full | (pix_last & (pix_valid | (lane_q != '0)));

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			wr_en    <= 1'b0;
			cap_done <= 1'b0;
			lane_q   <= '0;
			addr_q   <= '0;
		end else begin
			wr_en    <= flush;
			cap_done <= pix_last;

			// Next capture restarts at lane 0 of word 0
			if (pix_last)
				lane_q <= '0;
			else if (pix_valid)
				lane_q <= lane_q + 1'b1;

			if (pix_last)
				addr_q <= '0;
			else if (word_full)
				addr_q <= addr_q + 1'b1;
		end
	end

	// Payload path
	always_ff @(posedge CLOCK_50) begin
		if (pix_valid)
			buf_q <= word_n;
		wr_data <= word_n;
		wr_addr <= addr_q;
	end

endmodule

`default_nettype wire

/* hdl/frame_sampler.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_sampler (
	input  wire                     CLOCK_50,
	input  wire                     arst_n,
	input  wire                     arm,
	input  wire                     fval,
	input  wire                     lval,
	input  wire capture_pkg::pixel_t pix_d,
	output logic                    pix_valid,
	output capture_pkg::pixel_t     pix_data,
	output logic                    pix_last,
	output capture_pkg::pix_count_t pix_count
);

	// Previous flag values for edge detection
	logic fval_q;
	logic lval_q;
	logic fval_rise;
	logic fval_fall;
	logic lval_rise;

	// Capture window tracking
	logic active;
	logic spent;
	logic start;
	logic capturing;

	// Position in the frame
	logic        line_seen;
	logic [11:0] row_q;
	logic [11:0] col_q;
	logic [11:0] cur_row;
	logic [11:0] cur_col;

	logic keep;
	logic at_limit;

	assign fval_rise = fval & ~fval_q;
	assign fval_fall = ~fval & fval_q;
	assign lval_rise = lval & ~lval_q;

	// Only one frame per arming
	assign start     = arm & ~spent & fval_rise;
	assign capturing = active | start;

	// Row and column of the sample on this cycle
	always_comb begin
		cur_col = lval_rise ? '0 : col_q;
		if (!lval_rise)
			cur_row = row_q;
		else if (line_seen && !start)
			cur_row = row_q + 1'b1;
		else
			cur_row = '0;
	end

	// Decimate in both directions
	assign keep = capturing & fval & lval &
		(cur_row % capture_pkg::DECIM == 0) &
		(cur_col % capture_pkg::DECIM == 0);

	// Stale count on the start cycle must not trigger the limit
	assign at_limit = ~start &
		(pix_count == capture_pkg::pix_count_t'(capture_pkg::MAX_PIXELS - 1));

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			fval_q    <= 1'b0;
			lval_q    <= 1'b0;
			active    <= 1'b0;
			spent     <= 1'b0;
			line_seen <= 1'b0;
			row_q     <= '0;
			col_q     <= '0;
			pix_valid <= 1'b0;
			pix_last  <= 1'b0;
			pix_count <= '0;
		end else begin
			fval_q <= fval;
			lval_q <= lval;

			// Window ends at the pixel limit or when the frame closes
			if (keep && at_limit)
				active <= 1'b0;
			else if (start)
				active <= 1'b1;
			else if (fval_fall)
				active <= 1'b0;

			// Rearm only after arm has dropped
			if (!arm)
				spent <= 1'b0;
			else if (start)
				spent <= 1'b1;

			// New line
			if (capturing && lval_rise) begin
				row_q     <= cur_row;
				line_seen <= 1'b1;
			end else if (start) begin
				line_seen <= 1'b0;
			end

			if (capturing && fval && lval)
				col_q <= cur_col + 1'b1;

			// Count restarts with each capture
			if (start)
				pix_count <= capture_pkg::pix_count_t'(keep);
			else if (keep)
				pix_count <= pix_count + 1'b1;

			pix_valid <= keep;
			// Frame end may flag last without a pixel
			pix_last  <= (keep & at_limit) | (active & fval_fall);
		end
	end

	// Sample data, qualified by pix_valid
	always_ff @(posedge CLOCK_50) begin
		pix_data <= pix_d;
	end

endmodule

`default_nettype wire

/* hdl/capture_pkg.sv */
`default_nettype none

package capture_pkg;

	// One raw sample from the sensor
	typedef logic [11:0] pixel_t;

	// Host data word, pixel sits zero-extended in the low 12 bits
	typedef logic [15:0] host_word_t;

	// Packed memory word of sixteen 16-bit lanes
	// Lane i occupies bits 16i+15 down to 16i
	typedef logic [255:0] mem_word_t;

	// Wide port word address, 128 words
	typedef logic [6:0] waddr_t;

	// Host halfword address
	// Upper 7 bits pick the word, lower 4 bits pick the lane
	typedef logic [10:0] haddr_t;

	// Running count of kept pixels
	typedef logic [11:0] pix_count_t;

	// Lanes per memory word
	localparam int PIX_PER_WORD = 16;

	// Memory capacity in pixels
	localparam int MAX_PIXELS = 2048;

	// Keep a pixel when row and column are both multiples of this
	localparam int DECIM = 2;

endpackage

`default_nettype wire
